//--- Makefile
# Verilator simulation of the configuration subsystem testbench
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= cfg_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
FAIL_MSG  ?= Test failures found
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a verdict, see $(LOG)"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/cfg_ctrl_regs.sv
`include "cfg_params.svh"

module cfg_ctrl_regs (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cfg_read,
  input  logic                       cfg_write,
  input  logic [`CFG_OFFSET_W-1:0]   cfg_offset,
  input  logic [31:0]                cfg_wdata,
  output logic                       cfg_ack,
  output logic                       cfg_err,
  output logic [31:0]                cfg_rdata,
  // one enable bit per queue, held until rewritten
  output logic [`CFG_NUM_QUEUES-1:0] queue_enable,
  // write-one-to-clear pulses toward the high-water marks
  output logic [`CFG_NUM_QUEUES-1:0] hwm_clear
);

  // register map of this target
  localparam logic [`CFG_OFFSET_W-1:0] OFS_ENABLE = 'd0;
  localparam logic [`CFG_OFFSET_W-1:0] OFS_CLEAR  = 'd1;

  logic hit_enable;
  logic hit_clear;

  assign hit_enable = (cfg_offset == OFS_ENABLE);
  assign hit_clear  = (cfg_offset == OFS_CLEAR);

  // answer in the same cycle as the strobe
  always_comb begin
    cfg_ack   = cfg_read || cfg_write;
    cfg_err   = 1'b1;
    cfg_rdata = '0;
    if (hit_enable) begin
      cfg_err = 1'b0;
      if (cfg_read) begin
        cfg_rdata[`CFG_NUM_QUEUES-1:0] = queue_enable;
      end
    end else if (hit_clear) begin
      // the clear register has no storage and reads back as zero
      cfg_err = 1'b0;
    end
  end

  // all queues come out of reset enabled
  // upper write data bits have no queue behind them and are dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      queue_enable <= '1;
    end else if (cfg_write && hit_enable) begin
      queue_enable <= cfg_wdata[`CFG_NUM_QUEUES-1:0];
    end
  end

  // the written ones show for exactly the cycle after the accepting edge
  always_ff @(posedge clk) begin
    if (rst) begin
      hwm_clear <= '0;
    end else if (cfg_write && hit_clear) begin
      hwm_clear <= cfg_wdata[`CFG_NUM_QUEUES-1:0];
    end else begin
      hwm_clear <= '0;
    end
  end

  // requests are at least two cycles apart, so a clear never stretches
  a_clear_pulse: assert property (@(posedge clk) disable iff (rst)
    (|hwm_clear) |=> (hwm_clear == '0));

endmodule

//--- logic/cfg_params.svh
`ifndef CFG_PARAMS_SVH
`define CFG_PARAMS_SVH

// number of hardware queues covered by the configuration target
`define CFG_NUM_QUEUES 8

// occupancy counter and high-water mark widths, one word per queue
`define CFG_DEPTH_W 12
`define CFG_HWM_W 12

// read masks applied by the two status windows before data goes back
`define CFG_DEPTH_MASK 32'h0000_0fff
`define CFG_HWM_MASK 32'h0000_0fff

// register offset width on the configuration port
`define CFG_OFFSET_W 8

`endif

//--- logic/cfg_pkg.sv
`include "cfg_params.svh"

package cfg_pkg;

  // target select carried with every configuration request
  // the decoder routes on this field alone, the offset is passed through
  typedef enum logic [1:0] {
    // writable control registers (queue enable, high-water clear)
    TGT_CTRL  = 2'd0,
    // read-only window over the per-queue depth vector
    TGT_DEPTH = 2'd1,
    // read-only window over the per-queue high-water vector
    TGT_HWM   = 2'd2,
    // nothing is mapped here; every access returns an error
    TGT_NONE  = 2'd3
  } cfg_target_e;

  // index of one queue, sized from the queue count
  // enqueue and dequeue events name their queue with this type
  typedef logic [$clog2(`CFG_NUM_QUEUES)-1:0] queue_id_t;

endpackage

//--- logic/cfg_status_window.sv
`include "cfg_params.svh"

module cfg_status_window #(
  parameter int          DEPTH     = 8,
  parameter int          WIDTH     = 8,
  parameter logic [31:0] READ_MASK = '1
) (
  input  logic                     clk,
  input  logic                     rst,
  // flat status vector, queue 0 in the low word
  input  logic [DEPTH*WIDTH-1:0]   status,
  input  logic                     cfg_read,
  input  logic                     cfg_write,
  input  logic [`CFG_OFFSET_W-1:0] cfg_offset,
  input  logic [31:0]              cfg_wdata,
  output logic                     cfg_ack,
  output logic                     cfg_err,
  output logic [31:0]              cfg_rdata
);

  logic [31:0] word;

  // the vector is too wide for one access, so each offset selects one word
  always_comb begin
    word      = '0;
    cfg_ack   = cfg_read || cfg_write;
    cfg_err   = 1'b1;
    cfg_rdata = '0;
    // only an in-range read succeeds, writes are always refused
    if (cfg_read && (int'(cfg_offset) < DEPTH)) begin
      word[WIDTH-1:0] = status[int'(cfg_offset)*WIDTH +: WIDTH];
      cfg_err         = 1'b0;
      cfg_rdata       = word & READ_MASK;
    end
  end

  // a word must fit the 32-bit data path
  // and the decoder never issues a read and a write together
  a_window_legal: assert property (@(posedge clk) disable iff (rst)
    (WIDTH <= 32) && !(cfg_read && cfg_write));

  // write data is ignored here but should still be driven by the master
  a_wdata_known: assert property (@(posedge clk) disable iff (rst)
    cfg_write |-> !$isunknown(cfg_wdata));

endmodule

//--- logic/cfg_subsystem_top.sv
`include "cfg_params.svh"

module cfg_subsystem_top (
  input  logic                     clk,
  input  logic                     rst,
  // configuration request
  input  logic                     req_valid,
  output logic                     req_ready,
  input  logic                     req_write,
  input  cfg_pkg::cfg_target_e     req_target,
  input  logic [`CFG_OFFSET_W-1:0] req_offset,
  input  logic [31:0]              req_wdata,
  // configuration response
  output logic                     rsp_valid,
  input  logic                     rsp_ready,
  output logic                     rsp_err,
  output logic [31:0]              rsp_rdata,
  // queue activity events
  input  logic                     enq_valid,
  input  cfg_pkg::queue_id_t       enq_qid,
  input  logic                     deq_valid,
  input  cfg_pkg::queue_id_t       deq_qid
);

  // shared strobe bus from the decoder to the targets
  logic                                    ctrl_read;
  logic                                    ctrl_write;
  logic                                    depth_read;
  logic                                    depth_write;
  logic                                    hwm_read;
  logic                                    hwm_write;
  logic [`CFG_OFFSET_W-1:0]                cfg_offset;
  logic [31:0]                             cfg_wdata;
  // target answers
  logic                                    ctrl_ack;
  logic                                    ctrl_err;
  logic [31:0]                             ctrl_rdata;
  logic                                    depth_ack;
  logic                                    depth_err;
  logic [31:0]                             depth_rdata;
  logic                                    hwm_ack;
  logic                                    hwm_err;
  logic [31:0]                             hwm_rdata;
  // control outputs and status vectors
  logic [`CFG_NUM_QUEUES-1:0]              queue_enable;
  logic [`CFG_NUM_QUEUES-1:0]              hwm_clear;
  logic [`CFG_NUM_QUEUES*`CFG_DEPTH_W-1:0] depth_status;
  logic [`CFG_NUM_QUEUES*`CFG_HWM_W-1:0]   hwm_status;

  cfg_target_decode u_decode (.*);

  cfg_ctrl_regs u_ctrl_regs (
    .clk, .rst,
    .cfg_read (ctrl_read), .cfg_write (ctrl_write), .cfg_offset, .cfg_wdata,
    .cfg_ack (ctrl_ack), .cfg_err (ctrl_err), .cfg_rdata (ctrl_rdata),
    .queue_enable, .hwm_clear
  );

  queue_depth_track u_track (.*);

  // one window per status vector, each with its own word width and mask
  cfg_status_window #(.DEPTH(`CFG_NUM_QUEUES), .WIDTH(`CFG_DEPTH_W),
                      .READ_MASK(`CFG_DEPTH_MASK)) u_depth_window (
    .clk, .rst, .status (depth_status),
    .cfg_read (depth_read), .cfg_write (depth_write), .cfg_offset, .cfg_wdata,
    .cfg_ack (depth_ack), .cfg_err (depth_err), .cfg_rdata (depth_rdata)
  );

  cfg_status_window #(.DEPTH(`CFG_NUM_QUEUES), .WIDTH(`CFG_HWM_W),
                      .READ_MASK(`CFG_HWM_MASK)) u_hwm_window (
    .clk, .rst, .status (hwm_status),
    .cfg_read (hwm_read), .cfg_write (hwm_write), .cfg_offset, .cfg_wdata,
    .cfg_ack (hwm_ack), .cfg_err (hwm_err), .cfg_rdata (hwm_rdata)
  );

endmodule

//--- logic/cfg_target_decode.sv
`include "cfg_params.svh"

module cfg_target_decode (
  input  logic                     clk,
  input  logic                     rst,
  // request channel from the configuration master
  input  logic                     req_valid,
  output logic                     req_ready,
  input  logic                     req_write,
  input  cfg_pkg::cfg_target_e     req_target,
  input  logic [`CFG_OFFSET_W-1:0] req_offset,
  input  logic [31:0]              req_wdata,
  // registered response channel back to the master
  output logic                     rsp_valid,
  input  logic                     rsp_ready,
  output logic                     rsp_err,
  output logic [31:0]              rsp_rdata,
  // answers from the three targets, all combinational
  input  logic                     ctrl_ack,
  input  logic                     ctrl_err,
  input  logic [31:0]              ctrl_rdata,
  input  logic                     depth_ack,
  input  logic                     depth_err,
  input  logic [31:0]              depth_rdata,
  input  logic                     hwm_ack,
  input  logic                     hwm_err,
  input  logic [31:0]              hwm_rdata,
  // per-target strobes plus the shared offset and write data
  output logic                     ctrl_read,
  output logic                     ctrl_write,
  output logic                     depth_read,
  output logic                     depth_write,
  output logic                     hwm_read,
  output logic                     hwm_write,
  output logic [`CFG_OFFSET_W-1:0] cfg_offset,
  output logic [31:0]              cfg_wdata
);
  import cfg_pkg::*;

  logic        accept;
  logic        sel_ack;
  logic        sel_err;
  logic [31:0] sel_rdata;

  // a held response blocks the next request, so only one is ever in flight
  assign req_ready = !rsp_valid;
  assign accept    = req_valid && req_ready;

  // strobes only fire in the accepting cycle and only for the addressed target
  assign ctrl_read   = accept && !req_write && (req_target == TGT_CTRL);
  assign ctrl_write  = accept && req_write && (req_target == TGT_CTRL);
  assign depth_read  = accept && !req_write && (req_target == TGT_DEPTH);
  assign depth_write = accept && req_write && (req_target == TGT_DEPTH);
  assign hwm_read    = accept && !req_write && (req_target == TGT_HWM);
  assign hwm_write   = accept && req_write && (req_target == TGT_HWM);
  assign cfg_offset  = req_offset;
  assign cfg_wdata   = req_wdata;

  // pick the answer of the addressed target
  // the unmapped target keeps the defaults and so looks like a missing ack
  always_comb begin
    sel_ack   = 1'b0;
    sel_err   = 1'b1;
    sel_rdata = '0;
    case (req_target)
      TGT_CTRL: begin
        sel_ack   = ctrl_ack;
        sel_err   = ctrl_err;
        sel_rdata = ctrl_rdata;
      end
      TGT_DEPTH: begin
        sel_ack   = depth_ack;
        sel_err   = depth_err;
        sel_rdata = depth_rdata;
      end
      TGT_HWM: begin
        sel_ack   = hwm_ack;
        sel_err   = hwm_err;
        sel_rdata = hwm_rdata;
      end
      default: begin
      end
    endcase
  end

  // response valid rises one edge after acceptance and drops when it transfers
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else if (accept) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  // payload is only loaded on acceptance, so it holds under back-pressure
  // an error always comes back with zero data
  always_ff @(posedge clk) begin
    if (accept) begin
      rsp_err   <= !sel_ack || sel_err;
      rsp_rdata <= (sel_ack && !sel_err) ? sel_rdata : '0;
    end
  end

  // never more than one target is addressed in a cycle
  a_one_strobe: assert property (@(posedge clk) disable iff (rst)
    $onehot0({ctrl_read, ctrl_write, depth_read, depth_write, hwm_read, hwm_write}));

  // a stalled response keeps its contents until the master takes it
  a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_err) && $stable(rsp_rdata));

endmodule

//--- logic/queue_depth_track.sv
`include "cfg_params.svh"

module queue_depth_track (
  input  logic                                    clk,
  input  logic                                    rst,
  // single-cycle event pulses, never back-pressured
  input  logic                                    enq_valid,
  input  cfg_pkg::queue_id_t                      enq_qid,
  input  logic                                    deq_valid,
  input  cfg_pkg::queue_id_t                      deq_qid,
  input  logic [`CFG_NUM_QUEUES-1:0]              queue_enable,
  input  logic [`CFG_NUM_QUEUES-1:0]              hwm_clear,
  // flat status vectors, queue 0 in the low word
  output logic [`CFG_NUM_QUEUES*`CFG_DEPTH_W-1:0] depth_status,
  output logic [`CFG_NUM_QUEUES*`CFG_HWM_W-1:0]   hwm_status
);
  import cfg_pkg::*;

  localparam logic [`CFG_DEPTH_W-1:0] DEPTH_MAX = '1;

  logic [`CFG_DEPTH_W-1:0] depth_q [`CFG_NUM_QUEUES];
  logic [`CFG_HWM_W-1:0]   hwm_q   [`CFG_NUM_QUEUES];
  logic [`CFG_DEPTH_W-1:0] depth_nxt [`CFG_NUM_QUEUES];
  logic [`CFG_HWM_W-1:0]   hwm_nxt   [`CFG_NUM_QUEUES];

  always_comb begin
    logic inc;
    logic dec;
    for (int q = 0; q < `CFG_NUM_QUEUES; q++) begin
      // enqueues to a disabled queue are dropped on the floor
      inc = enq_valid && (enq_qid == queue_id_t'(q)) && queue_enable[q];
      dec = deq_valid && (deq_qid == queue_id_t'(q));
      depth_nxt[q] = depth_q[q];
      // an enqueue and a dequeue together pass straight through the queue
      if (inc && dec) begin
        depth_nxt[q] = depth_q[q];
      end else if (inc && (depth_q[q] != DEPTH_MAX)) begin
        depth_nxt[q] = depth_q[q] + 1'b1;
      end else if (dec && (depth_q[q] != '0)) begin
        // a dequeue of an empty queue is ignored
        depth_nxt[q] = depth_q[q] - 1'b1;
      end
      // clear restarts the mark from the depth being written this cycle
      hwm_nxt[q] = hwm_q[q];
      if (hwm_clear[q] || (`CFG_HWM_W'(depth_nxt[q]) > hwm_q[q])) begin
        hwm_nxt[q] = `CFG_HWM_W'(depth_nxt[q]);
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int q = 0; q < `CFG_NUM_QUEUES; q++) begin
      if (rst) begin
        depth_q[q] <= '0;
        hwm_q[q]   <= '0;
      end else begin
        depth_q[q] <= depth_nxt[q];
        hwm_q[q]   <= hwm_nxt[q];
      end
    end
  end

  // flatten the counters into the vectors the status windows read
  always_comb begin
    for (int q = 0; q < `CFG_NUM_QUEUES; q++) begin
      depth_status[q*`CFG_DEPTH_W +: `CFG_DEPTH_W] = depth_q[q];
      hwm_status[q*`CFG_HWM_W +: `CFG_HWM_W]       = hwm_q[q];
    end
  end

  // the mark can lag only if a clear or an update went wrong
  for (genvar g = 0; g < `CFG_NUM_QUEUES; g++) begin : g_hwm_chk
    a_hwm_ge_depth: assert property (@(posedge clk) disable iff (rst)
      hwm_q[g] >= `CFG_HWM_W'(depth_q[g]));
  end

endmodule

//--- src.f
+incdir+logic
logic/cfg_pkg.sv
logic/cfg_target_decode.sv
logic/cfg_status_window.sv
logic/cfg_ctrl_regs.sv
logic/queue_depth_track.sv
logic/cfg_subsystem_top.sv
verif/cfg_tb.sv

//--- verif/cfg_tb.sv
`include "cfg_params.svh"

module cfg_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import cfg_pkg::*;

  localparam int SEED    = 37;
  localparam int TIMEOUT = 100;
  localparam int NQ      = `CFG_NUM_QUEUES;
  localparam int DMAX    = (1 << `CFG_DEPTH_W) - 1;

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     req_valid;
  logic                     req_ready;
  logic                     req_write;
  cfg_target_e              req_target;
  logic [`CFG_OFFSET_W-1:0] req_offset;
  logic [31:0]              req_wdata;
  logic                     rsp_valid;
  logic                     rsp_ready;
  logic                     rsp_err;
  logic [31:0]              rsp_rdata;
  logic                     enq_valid;
  queue_id_t                enq_qid;
  logic                     deq_valid;
  queue_id_t                deq_qid;

  // reference model state, kept from the register map and the event rules
  logic [NQ-1:0]           m_enable;
  logic [NQ-1:0]           m_clear;
  logic [`CFG_DEPTH_W-1:0] m_depth [NQ];
  logic [`CFG_HWM_W-1:0]   m_hwm   [NQ];
  // response the model expects for the request that is in flight
  logic                    exp_err;
  logic [31:0]             exp_rdata;

  // random back-pressure on the response channel when set
  logic bp_on;
  int   mismatch_count = 0;
  int   protocol_count = 0;
  int   timeout_count  = 0;

  cfg_subsystem_top DUT (.*);

  always #4 clk = ~clk;

  // answer of the register map for one access as seen before the accepting edge
  function automatic void predict_response(input logic wr, input cfg_target_e tgt,
                                           input int ofs, output logic err,
                                           output logic [31:0] rdata);
    err   = 1'b1;
    rdata = '0;
    case (tgt)
      TGT_CTRL: begin
        // offset 1 is the clear register and always reads back as zero
        if (ofs == 0 || ofs == 1) err = 1'b0;
        if (ofs == 0 && !wr) rdata = 32'(m_enable);
      end
      TGT_DEPTH: begin
        if (!wr && ofs < NQ) begin
          err   = 1'b0;
          rdata = 32'(m_depth[ofs]) & `CFG_DEPTH_MASK;
        end
      end
      TGT_HWM: begin
        if (!wr && ofs < NQ) begin
          err   = 1'b0;
          rdata = 32'(m_hwm[ofs]) & `CFG_HWM_MASK;
        end
      end
      default: begin
      end
    endcase
  endfunction

  // model of the tracker and the control registers stepped once per clock edge
  always @(posedge clk) begin : model
    int          nd;
    logic        inc;
    logic        dec;
    logic        p_err;
    logic [31:0] p_rdata;
    if (rst) begin
      m_enable  <= '1;
      m_clear   <= '0;
      exp_err   <= 1'b0;
      exp_rdata <= '0;
      for (int q = 0; q < NQ; q++) begin
        m_depth[q] <= '0;
        m_hwm[q]   <= '0;
      end
    end else begin
      for (int q = 0; q < NQ; q++) begin
        inc = enq_valid && (int'(enq_qid) == q) && m_enable[q];
        dec = deq_valid && (int'(deq_qid) == q);
        nd  = int'(m_depth[q]);
        // an enqueue and a dequeue together cancel and a full queue saturates
        if (inc && !dec && nd < DMAX) nd = nd + 1;
        else if (dec && !inc && nd > 0) nd = nd - 1;
        m_depth[q] <= `CFG_DEPTH_W'(nd);
        if (m_clear[q] || nd > int'(m_hwm[q])) m_hwm[q] <= `CFG_HWM_W'(nd);
      end
      m_clear <= '0;
      if (req_valid && req_ready) begin
        predict_response(req_write, req_target, int'(req_offset), p_err, p_rdata);
        exp_err   <= p_err;
        exp_rdata <= p_rdata;
        // control writes land after the accepting edge and the clear lasts one cycle
        if (req_write && req_target == TGT_CTRL && req_offset == 0) begin
          m_enable <= req_wdata[NQ-1:0];
        end
        if (req_write && req_target == TGT_CTRL && req_offset == 1) begin
          m_clear <= req_wdata[NQ-1:0];
        end
      end
    end
  end

  a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> req_ready && !rsp_valid)
    else begin
      protocol_count++;
      $display("response channel was busy right after reset");
    end

  a_latency: assert property (@(posedge clk) disable iff (rst)
    req_valid && req_ready |=> rsp_valid)
    else begin
      protocol_count++;
      $display("response did not follow an accepted request by one cycle");
    end

  a_no_spurious: assert property (@(posedge clk) disable iff (rst)
    $rose(rsp_valid) |-> $past(req_valid && req_ready))
    else begin
      protocol_count++;
      $display("response appeared without an accepted request");
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && !req_ready && $stable(rsp_err)
                                && $stable(rsp_rdata))
    else begin
      protocol_count++;
      $display("stalled response was dropped, changed, or a new request was allowed");
    end

  a_rsp_err: assert property (@(posedge clk) disable iff (rst)
    rsp_valid && rsp_ready |-> rsp_err == exp_err)
    else begin
      mismatch_count++;
      $display("Mismatch rsp_err expected 0x%0h actual 0x%0h",
               $sampled(exp_err), $sampled(rsp_err));
    end

  a_rsp_rdata: assert property (@(posedge clk) disable iff (rst)
    rsp_valid && rsp_ready |-> rsp_rdata == exp_rdata)
    else begin
      mismatch_count++;
      $display("Mismatch rsp_rdata expected 0x%08h actual 0x%08h",
               $sampled(exp_rdata), $sampled(rsp_rdata));
    end

  // one full request and response that starts and ends just after a falling edge
  task automatic issue_request(input logic wr, input cfg_target_e tgt,
                               input logic [`CFG_OFFSET_W-1:0] ofs, input logic [31:0] wd);
    int   waited;
    logic done;
    req_valid  = 1'b1;
    req_write  = wr;
    req_target = tgt;
    req_offset = ofs;
    req_wdata  = wd;
    waited     = 0;
    while (!req_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!req_ready) begin
      timeout_count++;
      $display("request was not accepted within %0d cycles", TIMEOUT);
    end
    // ready was high before this edge, so the request goes over on it
    @(negedge clk);
    req_valid = 1'b0;
    waited    = 0;
    done      = 1'b0;
    while (!done && waited < TIMEOUT) begin
      rsp_ready = bp_on ? ($urandom_range(0, 2) == 0) : 1'b1;
      done      = rsp_valid && rsp_ready;
      @(negedge clk);
      waited++;
    end
    if (!done) begin
      timeout_count++;
      $display("response was not taken within %0d cycles", TIMEOUT);
    end
  endtask

  // random enqueue and dequeue pulses biased by the given percentages
  task automatic drive_events(input int cycles, input int enq_pct, input int deq_pct);
    for (int i = 0; i < cycles; i++) begin
      enq_valid = ($urandom_range(0, 99) < enq_pct);
      enq_qid   = queue_id_t'($urandom_range(0, NQ - 1));
      deq_valid = ($urandom_range(0, 99) < deq_pct);
      deq_qid   = queue_id_t'($urandom_range(0, NQ - 1));
      @(negedge clk);
    end
    enq_valid = 1'b0;
    deq_valid = 1'b0;
  endtask

  initial begin
    void'($urandom(SEED));
    rst        = 1'b1;
    req_valid  = 1'b0;
    req_write  = 1'b0;
    req_target = TGT_CTRL;
    req_offset = '0;
    req_wdata  = '0;
    rsp_ready  = 1'b1;
    enq_valid  = 1'b0;
    enq_qid    = '0;
    deq_valid  = 1'b0;
    deq_qid    = '0;
    bp_on      = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);

    // the enable register reads back what was written and other control offsets are refused
    issue_request(1'b0, TGT_CTRL, 8'd0, '0);
    issue_request(1'b1, TGT_CTRL, 8'd0, $urandom);
    issue_request(1'b0, TGT_CTRL, 8'd0, '0);
    issue_request(1'b0, TGT_CTRL, 8'd1, '0);
    issue_request(1'b0, TGT_CTRL, 8'd2, '0);
    issue_request(1'b1, TGT_CTRL, 8'($urandom_range(3, 255)), $urandom);

    // fill with some queues disabled, drain past empty, then refill
    issue_request(1'b1, TGT_CTRL, 8'd0, 32'h0000_005a);
    drive_events(60, 70, 25);
    drive_events(40, 10, 85);
    issue_request(1'b1, TGT_CTRL, 8'd0, 32'h0000_00ff);
    drive_events(60, 75, 30);
    for (int q = 0; q < NQ; q++) begin
      issue_request(1'b0, TGT_DEPTH, 8'(q), '0);
    end

    // marks keep the peak while depths fall, a clear brings them down to depth
    for (int q = 0; q < NQ; q++) begin
      issue_request(1'b0, TGT_HWM, 8'(q), '0);
    end
    drive_events(40, 5, 90);
    for (int q = 0; q < NQ; q++) begin
      issue_request(1'b0, TGT_HWM, 8'(q), '0);
    end
    issue_request(1'b1, TGT_CTRL, 8'd1, 32'h0000_00ff);
    for (int q = 0; q < NQ; q++) begin
      issue_request(1'b0, TGT_HWM, 8'(q), '0);
      issue_request(1'b0, TGT_DEPTH, 8'(q), '0);
    end

    // status windows refuse writes and out of range reads, the unmapped target refuses all
    issue_request(1'b1, TGT_DEPTH, 8'd0, $urandom);
    issue_request(1'b1, TGT_HWM, 8'd3, $urandom);
    issue_request(1'b0, TGT_DEPTH, 8'(NQ), '0);
    issue_request(1'b0, TGT_HWM, 8'($urandom_range(NQ, 255)), '0);
    issue_request(1'b0, TGT_NONE, 8'd0, '0);
    issue_request(1'b1, TGT_NONE, 8'd1, $urandom);

    // mixed traffic with the master stalling the response at random
    bp_on = 1'b1;
    for (int i = 0; i < 40; i++) begin
      issue_request($urandom_range(0, 3) == 0, cfg_target_e'($urandom_range(0, 3)),
                    8'($urandom_range(0, NQ + 1)), $urandom);
      if (i % 8 == 0) begin
        drive_events(10, 60, 40);
      end
    end
    bp_on = 1'b0;
    repeat (4) @(negedge clk);

    $display("errors: mismatch %0d, protocol %0d, timeout %0d",
             mismatch_count, protocol_count, timeout_count);
    if (mismatch_count + protocol_count + timeout_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
